// File: bench/exec_tb.sv
`timescale 1ns/10ps
`include "rv32_exec_consts.svh"

module exec_tb;

    // ops issued over the whole run, sizes the watchdog
    localparam int N_OPS = 2 * 17 + 1 + 256 + 200 + 60 + 30 * 7 + 3 * 2 + 13 + 2;
    localparam int WATCHDOG_NS = N_OPS * 20 + 2000;

    logic                 clk;
    logic                 rst_n;
    logic                 op_valid;
    rv32_exec_pkg::opt_t  opt;
    rv32_exec_pkg::word_t rs1_d;
    rv32_exec_pkg::word_t rs2_d;
    rv32_exec_pkg::word_t imm;
    rv32_exec_pkg::word_t pc;
    rv32_exec_pkg::word_t rd_d;
    logic                 halted;
    rv32_exec_pkg::word_t exit_code;

    // reference model state
    rv32_exec_pkg::word_t shadow [0:`DMEM_WORDS-1];
    rv32_exec_pkg::word_t model_pc;
    rv32_exec_pkg::word_t model_exit;
    logic                 model_halted;
    rv32_exec_pkg::word_t exp_rd;
    logic                 chk_en;
    logic [31:0]          rng;
    int                   n_checks;
    int                   n_errors;

    exec_top i_exec_top (
        .clk       (clk       ),
        .rst_n     (rst_n     ),
        .op_valid  (op_valid  ),
        .opt       (opt       ),
        .rs1_d     (rs1_d     ),
        .rs2_d     (rs2_d     ),
        .imm       (imm       ),
        .pc        (pc        ),
        .rd_d      (rd_d      ),
        .halted    (halted    ),
        .exit_code (exit_code )
    );

    // 20 ns period
    always #10 clk = ~clk;

    // ------------------------------------------------------------------
    // helpers
    // ------------------------------------------------------------------
    // xorshift32 step
    function automatic logic [31:0] next_rand();
        rng = rng ^ (rng << 13);
        rng = rng ^ (rng >> 17);
        rng = rng ^ (rng << 5);
        return rng;
    endfunction

    // preload pattern, every address bit matters
    function automatic rv32_exec_pkg::word_t fill_word(input rv32_exec_pkg::word_t a);
        return (a * 32'h9e37_79b9) ^ {a[15:0], a[31:16]};
    endfunction

    function automatic rv32_exec_pkg::opt_t encode_op(input logic [1:0] src,
            input logic [2:0] alu, input logic [1:0] pcc, input logic [1:0] msz,
            input logic ld, input logic ext, input logic sgn, input logic neg);
        rv32_exec_pkg::opt_t o;
        o = 16'd0;
        o[`OPT_SRC_HI:`OPT_SRC_LO] = src;
        o[`OPT_ALU_HI:`OPT_ALU_LO] = alu;
        o[`OPT_PC_HI:`OPT_PC_LO]   = pcc;
        o[`OPT_MEM_HI:`OPT_MEM_LO] = msz;
        o[`OPT_LOAD] = ld;
        o[`OPT_EXT]  = ext;
        o[`OPT_SIGN] = sgn;
        o[`OPT_NEG]  = neg;
        return o;
    endfunction

    // integer result per the alu rules, link value included
    function automatic rv32_exec_pkg::word_t alu_model(input rv32_exec_pkg::opt_t o,
            input rv32_exec_pkg::word_t r1, input rv32_exec_pkg::word_t r2,
            input rv32_exec_pkg::word_t im, input rv32_exec_pkg::word_t cur_pc);
        rv32_exec_pkg::word_t a;
        rv32_exec_pkg::word_t b;
        rv32_exec_pkg::word_t res;
        logic [1:0]           src;
        logic                 flag;
        src = o[`OPT_SRC_HI:`OPT_SRC_LO];
        a = (src == 2'd0) ? im : ((src == 2'd1) ? cur_pc : r1);
        b = (src == 2'd0) ? 32'd0 : ((src == 2'd2) ? r2 : im);
        case (o[`OPT_ALU_HI:`OPT_ALU_LO])
            3'd0: res = o[`OPT_NEG] ? a - b : a + b;
            3'd1: res = a << b[4:0];
            3'd2: begin
                flag = o[`OPT_SIGN] ? ($signed(a) < $signed(b)) : (a < b);
                res  = {31'd0, flag ^ o[`OPT_NEG]};
            end
            3'd3: res = {31'd0, (a == b) ^ o[`OPT_NEG]};
            3'd4: res = a ^ b;
            3'd5: begin
                if (o[`OPT_EXT]) begin
                    res = $signed(a) >>> b[4:0];
                end else begin
                    res = a >> b[4:0];
                end
            end
            3'd6: res = a | b;
            default: res = a & b;
        endcase
        // jal/jalr style word
        if ((o[`OPT_MEM_HI:`OPT_MEM_LO] == 2'd0) && o[`OPT_LOAD]
                && (o[`OPT_PC_HI:`OPT_PC_LO] != `PC_BRANCH)) begin
            res = cur_pc + 32'd4;
        end
        return res;
    endfunction

    // expected {rd_d, dnpc}, loads gathered byte by byte from the shadow
    function automatic logic [63:0] ref_exec(input rv32_exec_pkg::opt_t o,
            input rv32_exec_pkg::word_t r1, input rv32_exec_pkg::word_t r2,
            input rv32_exec_pkg::word_t im, input rv32_exec_pkg::word_t cur_pc);
        rv32_exec_pkg::word_t res;
        rv32_exec_pkg::word_t w;
        rv32_exec_pkg::word_t rd;
        rv32_exec_pkg::word_t nxt;
        logic [1:0]           sz;
        logic [1:0]           pcc;
        logic                 ext_bit;
        int                   off;
        int                   nb;
        int                   k;
        res = alu_model(o, r1, r2, im, cur_pc);
        sz  = o[`OPT_MEM_HI:`OPT_MEM_LO];
        pcc = o[`OPT_PC_HI:`OPT_PC_LO];
        rd  = res;
        if ((sz != 2'd0) && o[`OPT_LOAD]) begin
            w   = shadow[(res >> 2) % `DMEM_WORDS];
            off = res[1:0];
            nb  = (sz == 2'd3) ? 4 : sz;
            rd  = 32'd0;
            for (k = 0; k < nb; k++) begin
                rd[8 * k +: 8] = w[8 * (off + k) +: 8];
            end
            ext_bit = o[`OPT_SIGN] & rd[8 * nb - 1];
            for (k = nb; k < 4; k++) begin
                rd[8 * k +: 8] = {8{ext_bit}};
            end
        end
        // branch decision from result bit 0
        if (pcc == `PC_BRANCH) begin
            pcc = res[0] ? `PC_REL : `PC_SEQ;
        end
        case (pcc)
            `PC_SEQ: nxt = cur_pc + 32'd4;
            `PC_REL: nxt = cur_pc + im;
            default: nxt = r1 + im;
        endcase
        return {rd, nxt};
    endfunction

    task automatic store_shadow(input rv32_exec_pkg::word_t addr,
            input rv32_exec_pkg::word_t data, input logic [1:0] sz);
        rv32_exec_pkg::word_t w;
        int                   idx;
        int                   off;
        int                   nb;
        int                   k;
        idx = (addr >> 2) % `DMEM_WORDS;
        off = addr[1:0];
        nb  = (sz == 2'd3) ? 4 : sz;
        w   = shadow[idx];
        for (k = 0; k < nb; k++) begin
            w[8 * (off + k) +: 8] = data[8 * k +: 8];
        end
        shadow[idx] = w;
    endtask

    task automatic compare_word(input string what, input rv32_exec_pkg::word_t got,
            input rv32_exec_pkg::word_t want);
        n_checks++;
        if (got !== want) begin
            n_errors++;
            $display("Mismatch at %0t: %s got %h expected %h", $time, what, got, want);
        end
    endtask

    // drives one op, then retires it in the model on the edge
    task automatic issue_op(input logic v, input rv32_exec_pkg::opt_t o,
            input rv32_exec_pkg::word_t r1, input rv32_exec_pkg::word_t r2,
            input rv32_exec_pkg::word_t im);
        logic [63:0]          ref_v;
        rv32_exec_pkg::word_t addr;
        op_valid = v;
        opt      = o;
        rs1_d    = r1;
        rs2_d    = r2;
        imm      = im;
        ref_v    = ref_exec(o, r1, r2, im, model_pc);
        addr     = alu_model(o, r1, r2, im, model_pc);
        exp_rd   = ref_v[63:32];
        @(posedge clk);
        if (v && !model_halted) begin
            if (o[14:0] == 15'd0) begin
                model_halted = 1'b1;
                model_exit   = o[`OPT_NEG] ? r1 : `DEFAULT_EXIT;
            end else begin
                model_pc = ref_v[31:0];
                if ((o[`OPT_MEM_HI:`OPT_MEM_LO] != 2'd0) && !o[`OPT_LOAD]) begin
                    store_shadow(addr, r2, o[`OPT_MEM_HI:`OPT_MEM_LO]);
                end
            end
        end
        #2;
    endtask

    // 16 cycles low, memory and shadow keep their contents
    task automatic apply_reset();
        logic [63:0] ref_v;
        chk_en   = 1'b0;
        rst_n    = 1'b0;
        op_valid = 1'b0;
        opt      = 16'd0;
        rs1_d    = 32'd0;
        rs2_d    = 32'd0;
        imm      = 32'd0;
        repeat (16) @(posedge clk);
        #2;
        rst_n        = 1'b1;
        model_pc     = `RESET_PC;
        model_halted = 1'b0;
        model_exit   = 32'd0;
        ref_v        = ref_exec(opt, rs1_d, rs2_d, imm, model_pc);
        exp_rd       = ref_v[63:32];
        chk_en       = 1'b1;
    endtask

    // ------------------------------------------------------------------
    // checker, samples 3 ns before the next edge
    // ------------------------------------------------------------------
    always begin
        @(posedge clk);
        #17;
        if (chk_en) begin
            compare_word("pc", pc, model_pc);
            compare_word("halted", {31'd0, halted}, {31'd0, model_halted});
            compare_word("exit_code", exit_code, model_exit);
            compare_word("rd_d", rd_d, exp_rd);
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired after %0d ns, the op sequence never finished", WATCHDOG_NS);
        $display("checks %0d errors %0d", n_checks, n_errors);
        $display("TEST FAILED");
        $finish;
    end

    // ------------------------------------------------------------------
    // stimulus
    // ------------------------------------------------------------------
    initial begin : main_seq
        rv32_exec_pkg::word_t r;
        rv32_exec_pkg::word_t addr;
        rv32_exec_pkg::word_t la;
        rv32_exec_pkg::word_t ofs;
        rv32_exec_pkg::word_t halt_addr [0:3];
        logic [1:0]           sz;
        int                   i;
        int                   ls;
        int                   sg;
        clk      = 1'b0;
        rng      = 32'hd809;
        n_checks = 0;
        n_errors = 0;
        apply_reset();
        // reset values checked in this idle cycle
        issue_op(1'b0, 16'd0, 32'd0, 32'd0, 32'd0);

        // word stores over the whole memory
        for (i = 0; i < `DMEM_WORDS; i++) begin
            addr = i * 4;
            issue_op(1'b1, encode_op(2'd3, 3'd0, `PC_SEQ, 2'd3, 1'b0, 1'b0, 1'b0, 1'b0),
                addr, fill_word(addr), 32'd0);
        end

        // alu ops, every op under every operand select
        for (i = 0; i < 200; i++) begin
            r = next_rand();
            issue_op(1'b1, encode_op(i[4:3], i[2:0], `PC_SEQ, 2'd0, 1'b0, r[0], r[1], r[2]),
                next_rand(), next_rand(), next_rand());
        end

        // branches, jal, jalr
        for (i = 0; i < 60; i++) begin
            r    = next_rand();
            ofs  = {{19{r[12]}}, r[12:2], 2'b00};
            addr = next_rand();
            if (i % 3 == 0) begin
                issue_op(1'b1, encode_op(2'd2, r[16] ? 3'd3 : 3'd2, `PC_BRANCH, 2'd0, 1'b0,
                    1'b0, r[17], r[18]), addr, r[19] ? addr : next_rand(), ofs);
            end else if (i % 3 == 1) begin
                issue_op(1'b1, encode_op(2'd1, 3'd0, `PC_REL, 2'd0, 1'b1, 1'b0, 1'b0, 1'b0),
                    addr, next_rand(), ofs);
            end else begin
                issue_op(1'b1, encode_op(2'd3, 3'd0, `PC_REG, 2'd0, 1'b1, 1'b0, 1'b0, 1'b0),
                    {addr[31:2], 2'b00}, next_rand(), ofs);
            end
        end

        // each store followed by every load size, signed and unsigned
        for (i = 0; i < 30; i++) begin
            r    = next_rand();
            sz   = (r[1:0] == 2'd0) ? 2'd3 : r[1:0];
            addr = {22'd0, r[9:2], 2'b00};
            if (sz == 2'd1) begin
                addr[1:0] = r[11:10];
            end else if (sz == 2'd2) begin
                addr[1] = r[10];
            end
            ofs = {{20{r[23]}}, r[23:12]};
            issue_op(1'b1, encode_op(2'd3, 3'd0, `PC_SEQ, sz, 1'b0, 1'b0, 1'b0, 1'b0),
                addr - ofs, next_rand(), ofs);
            for (ls = 1; ls <= 3; ls++) begin
                for (sg = 0; sg < 2; sg++) begin
                    la = (ls == 3) ? (addr & ~32'd3) : ((ls == 2) ? (addr & ~32'd1) : addr);
                    issue_op(1'b1, encode_op(2'd3, 3'd0, `PC_SEQ, ls[1:0], 1'b1, 1'b0,
                        sg[0], 1'b0), la, next_rand(), 32'd0);
                end
            end
        end

        // store with op_valid low, then read the word back
        for (i = 0; i < 3; i++) begin
            r    = next_rand();
            addr = {22'd0, r[9:2], 2'b00};
            issue_op(1'b0, encode_op(2'd3, 3'd0, `PC_SEQ, 2'd3, 1'b0, 1'b0, 1'b0, 1'b0),
                addr, ~r, 32'd0);
            issue_op(1'b1, encode_op(2'd3, 3'd0, `PC_SEQ, 2'd3, 1'b1, 1'b0, 1'b0, 1'b0),
                addr, 32'd0, 32'd0);
        end

        // ebreak with exit code from rs1
        issue_op(1'b1, encode_op(2'd0, 3'd0, `PC_BRANCH, 2'd0, 1'b0, 1'b0, 1'b0, 1'b1),
            next_rand(), next_rand(), next_rand());
        // halted, stores and jumps must not retire
        for (i = 0; i < 4; i++) begin
            r            = next_rand();
            halt_addr[i] = {22'd0, r[9:2], 2'b00};
            issue_op(1'b1, encode_op(2'd3, 3'd0, `PC_SEQ, 2'd3, 1'b0, 1'b0, 1'b0, 1'b0),
                halt_addr[i], ~r, 32'd0);
            issue_op(1'b1, encode_op(2'd1, 3'd0, `PC_REL, 2'd0, 1'b1, 1'b0, 1'b0, 1'b0),
                r, r, {r[31:2], 2'b00});
        end
        for (i = 0; i < 4; i++) begin
            issue_op(1'b1, encode_op(2'd3, 3'd0, `PC_SEQ, 2'd3, 1'b1, 1'b0, 1'b0, 1'b0),
                halt_addr[i], 32'd0, 32'd0);
        end

        // second run, plain ebreak gives the default code
        apply_reset();
        issue_op(1'b1, 16'd0, next_rand(), next_rand(), next_rand());
        issue_op(1'b0, 16'd0, 32'd0, 32'd0, 32'd0);

        $display("checks %0d errors %0d", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// File: rtl/core_state_regs.sv
`timescale 1ns/10ps
`include "rv32_exec_consts.svh"

module core_state_regs (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 advance,
    input  rv32_exec_pkg::word_t dnpc,
    input  logic                 halt_req,
    input  rv32_exec_pkg::word_t halt_code,
    output rv32_exec_pkg::word_t pc,
    output rv32_exec_pkg::word_t exit_code,
    output logic                 halted
);
    rv32_exec_pkg::run_state_t state;

    // ------------------------------------------------------------------
    // pc register
    // ------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc <= `RESET_PC;
        end else if (advance) begin
            pc <= dnpc;
        end
    end

    // ------------------------------------------------------------------
    // run/halt fsm, only reset leaves HALTED
    // ------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state     <= rv32_exec_pkg::RUNNING;
            exit_code <= 32'd0;
        end else if ((state == rv32_exec_pkg::RUNNING) && halt_req) begin
            state     <= rv32_exec_pkg::HALTED;
            // code latched on the halting edge
            exit_code <= halt_code;
        end
    end

    assign halted = (state == rv32_exec_pkg::HALTED);

    // the execute stage must stop requesting once halted
    a_no_req_when_halted: assert property (
        @(posedge clk) disable iff (!rst_n)
        halt_req |-> (state == rv32_exec_pkg::RUNNING)
    );

endmodule

// File: rtl/data_mem.sv
`timescale 1ns/10ps
`include "rv32_exec_consts.svh"

module data_mem (
    input  logic                 clk,
    input  rv32_exec_pkg::word_t addr,
    input  rv32_exec_pkg::word_t wdata,
    input  logic [3:0]           wmask,
    input  logic                 we,
    output rv32_exec_pkg::word_t rdata
);
    localparam int AW = $clog2(`DMEM_WORDS);

    // word array, contents survive reset
    rv32_exec_pkg::word_t mem [0:`DMEM_WORDS-1];
    logic [AW-1:0]        idx;

    // word index, upper bits dropped so reads wrap
    assign idx = addr[AW+1:2];

    // ------------------------------------------------------------------
    // read port, combinational
    // ------------------------------------------------------------------
    assign rdata = mem[idx];

    // ------------------------------------------------------------------
    // write port, byte lanes on the edge
    // ------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (we) begin
            for (int i = 0; i < 4; i++) begin
                if (wmask[i]) begin
                    mem[idx][8*i +: 8] <= wdata[8*i +: 8];
                end
            end
        end
    end

    // stores must stay inside the array, no wrap on writes
    a_waddr_in_range: assert property (
        @(posedge clk) we |-> (addr[31:2] < `DMEM_WORDS)
    );

endmodule

// File: rtl/exec_alu.sv
`timescale 1ns/10ps

module exec_alu (
    input  rv32_exec_pkg::word_t   a,
    input  rv32_exec_pkg::word_t   b,
    input  rv32_exec_pkg::word_t   pc,
    input  rv32_exec_pkg::alu_op_t op,
    input  logic                   link,
    input  logic                   ext,
    input  logic                   sign,
    input  logic                   neg,
    output rv32_exec_pkg::word_t   res
);
    // shared adder-subtractor
    rv32_exec_pkg::word_t b_in;
    rv32_exec_pkg::word_t sum;
    // barrel shifter
    rv32_exec_pkg::word_t shl;
    rv32_exec_pkg::word_t srl;
    rv32_exec_pkg::word_t sra;
    rv32_exec_pkg::word_t shr;
    logic [4:0]           shamt;
    // comparator
    logic                 lt;
    logic                 eq;

    // two's complement subtract when neg set
    assign b_in = neg ? ~b : b;
    assign sum  = a + b_in + {31'd0, neg};

    assign shamt = b[4:0];
    assign shl   = a << shamt;
    assign srl   = a >> shamt;
    // arithmetic shift fills with the sign bit
    assign sra   = $signed(a) >>> shamt;
    assign shr   = ext ? sra : srl;

    assign lt = sign ? ($signed(a) < $signed(b)) : (a < b);
    assign eq = (a == b);

    always_comb begin
        case (op)
            3'd0: res = sum;
            3'd1: res = shl;
            // neg flips the one-bit compare for bge/bne style ops
            3'd2: res = {31'd0, lt ^ neg};
            3'd3: res = {31'd0, eq ^ neg};
            3'd4: res = a ^ b;
            3'd5: res = shr;
            3'd6: res = a | b;
            default: res = a & b;
        endcase
        // jal/jalr write back the return address
        if (link) begin
            res = pc + 32'd4;
        end
    end

endmodule

// File: rtl/exec_top.sv
`timescale 1ns/10ps

module exec_top (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 op_valid,
    input  rv32_exec_pkg::opt_t  opt,
    input  rv32_exec_pkg::word_t rs1_d,
    input  rv32_exec_pkg::word_t rs2_d,
    input  rv32_exec_pkg::word_t imm,
    output rv32_exec_pkg::word_t pc,
    output rv32_exec_pkg::word_t rd_d,
    output logic                 halted,
    output rv32_exec_pkg::word_t exit_code
);
    // exu to state block
    rv32_exec_pkg::word_t dnpc;
    rv32_exec_pkg::word_t halt_code;
    logic                 halt_req;
    logic                 advance;
    // exu to data memory
    rv32_exec_pkg::word_t mem_addr;
    rv32_exec_pkg::word_t mem_wdata;
    rv32_exec_pkg::word_t mem_rdata;
    logic [3:0]           mem_wmask;
    logic                 mem_we;

    exu u_exu (
        .clk       (clk       ),
        .op_valid  (op_valid  ),
        .halted    (halted    ),
        .opt       (opt       ),
        .rs1_d     (rs1_d     ),
        .rs2_d     (rs2_d     ),
        .imm       (imm       ),
        .pc        (pc        ),
        .mem_rdata (mem_rdata ),
        .rd_d      (rd_d      ),
        .dnpc      (dnpc      ),
        .mem_addr  (mem_addr  ),
        .mem_wdata (mem_wdata ),
        .halt_code (halt_code ),
        .mem_wmask (mem_wmask ),
        .mem_we    (mem_we    ),
        .halt_req  (halt_req  ),
        .advance   (advance   )
    );

    data_mem u_data_mem (
        .clk   (clk       ),
        .addr  (mem_addr  ),
        .wdata (mem_wdata ),
        .wmask (mem_wmask ),
        .we    (mem_we    ),
        .rdata (mem_rdata )
    );

    core_state_regs u_core_state_regs (
        .clk       (clk       ),
        .rst_n     (rst_n     ),
        .advance   (advance   ),
        .dnpc      (dnpc      ),
        .halt_req  (halt_req  ),
        .halt_code (halt_code ),
        .pc        (pc        ),
        .exit_code (exit_code ),
        .halted    (halted    )
    );

endmodule

// File: rtl/exu.sv
`timescale 1ns/10ps
`include "rv32_exec_consts.svh"

module exu (
    input  logic                 clk,
    input  logic                 op_valid,
    input  logic                 halted,
    input  rv32_exec_pkg::opt_t  opt,
    input  rv32_exec_pkg::word_t rs1_d,
    input  rv32_exec_pkg::word_t rs2_d,
    input  rv32_exec_pkg::word_t imm,
    input  rv32_exec_pkg::word_t pc,
    input  rv32_exec_pkg::word_t mem_rdata,
    output rv32_exec_pkg::word_t rd_d,
    output rv32_exec_pkg::word_t dnpc,
    output rv32_exec_pkg::word_t mem_addr,
    output rv32_exec_pkg::word_t mem_wdata,
    output rv32_exec_pkg::word_t halt_code,
    output logic [3:0]           mem_wmask,
    output logic                 mem_we,
    output logic                 halt_req,
    output logic                 advance
);
    logic [1:0]                src_sel;
    rv32_exec_pkg::alu_op_t    alu_op;
    rv32_exec_pkg::pc_sel_t    pc_ctl;
    rv32_exec_pkg::mem_size_t  msize;
    logic                      is_load;
    logic                      is_store;
    logic                      is_halt;
    logic                      link;
    logic                      run;
    rv32_exec_pkg::word_t      op_a;
    rv32_exec_pkg::word_t      op_b;
    rv32_exec_pkg::word_t      res;
    rv32_exec_pkg::word_t      ld_word;
    rv32_exec_pkg::word_t      ld_data;
    logic [4:0]                lane_sh;
    logic [3:0]                size_mask;

    // ------------------------------------------------------------------
    // control word decode
    // ------------------------------------------------------------------
    assign src_sel  = opt[`OPT_SRC_HI:`OPT_SRC_LO];
    assign alu_op   = opt[`OPT_ALU_HI:`OPT_ALU_LO];
    assign pc_ctl   = opt[`OPT_PC_HI:`OPT_PC_LO];
    assign msize    = opt[`OPT_MEM_HI:`OPT_MEM_LO];
    assign is_load  = (msize != 2'd0) && opt[`OPT_LOAD];
    assign is_store = (msize != 2'd0) && !opt[`OPT_LOAD];
    // load bit without a size marks jal/jalr
    assign link     = (msize == 2'd0) && opt[`OPT_LOAD] && (pc_ctl != `PC_BRANCH);
    // ebreak class, everything but neg clear
    assign is_halt  = (opt[14:0] == 15'd0);

    // op qualified once here, nothing retires after halt
    assign run      = op_valid && !halted;
    assign advance  = run && !is_halt;
    assign halt_req = run && is_halt;
    assign mem_we   = run && is_store;

    // exit code
    assign halt_code = opt[`OPT_NEG] ? rs1_d : `DEFAULT_EXIT;

    // ------------------------------------------------------------------
    // operands and alu
    // ------------------------------------------------------------------
    always_comb begin
        case (src_sel)
            2'd0: begin
                op_a = imm;
                op_b = 32'd0;
            end
            2'd1: begin
                op_a = pc;
                op_b = imm;
            end
            2'd2: begin
                op_a = rs1_d;
                op_b = rs2_d;
            end
            default: begin
                op_a = rs1_d;
                op_b = imm;
            end
        endcase
    end

    exec_alu u_exec_alu (
        .a    (op_a             ),
        .b    (op_b             ),
        .pc   (pc               ),
        .op   (alu_op           ),
        .link (link             ),
        .ext  (opt[`OPT_EXT]    ),
        .sign (opt[`OPT_SIGN]   ),
        .neg  (opt[`OPT_NEG]    ),
        .res  (res              )
    );

    // res bit 0 carries the branch decision
    next_pc_unit u_next_pc_unit (
        .clk    (clk    ),
        .valid  (advance),
        .pc_ctl (pc_ctl ),
        .taken  (res[0] ),
        .pc     (pc     ),
        .rs1_d  (rs1_d  ),
        .imm    (imm    ),
        .dnpc   (dnpc   )
    );

    // ------------------------------------------------------------------
    // memory lanes
    // ------------------------------------------------------------------
    assign mem_addr = res;
    // 8 times the byte offset
    assign lane_sh  = {res[1:0], 3'b000};

    always_comb begin
        case (msize)
            2'd1: size_mask = 4'b0001;
            2'd2: size_mask = 4'b0011;
            2'd3: size_mask = 4'b1111;
            default: size_mask = 4'b0000;
        endcase
    end

    assign mem_wmask = size_mask << res[1:0];
    assign mem_wdata = rs2_d << lane_sh;

    // load data shifted down, then extended
    assign ld_word = mem_rdata >> lane_sh;

    always_comb begin
        case (msize)
            2'd1: ld_data = {{24{ld_word[7] & opt[`OPT_SIGN]}}, ld_word[7:0]};
            2'd2: ld_data = {{16{ld_word[15] & opt[`OPT_SIGN]}}, ld_word[15:0]};
            default: ld_data = ld_word;
        endcase
    end

    assign rd_d = is_load ? ld_data : res;

    // misaligned accesses are not supported
    a_half_aligned: assert property (
        @(posedge clk) (run && (msize == 2'd2)) |-> !mem_addr[0]
    );
    a_word_aligned: assert property (
        @(posedge clk) (run && (msize == 2'd3)) |-> (mem_addr[1:0] == 2'b00)
    );

endmodule

// File: rtl/next_pc_unit.sv
`timescale 1ns/10ps
`include "rv32_exec_consts.svh"

module next_pc_unit (
    input  logic                   clk,
    input  logic                   valid,
    input  rv32_exec_pkg::pc_sel_t pc_ctl,
    input  logic                   taken,
    input  rv32_exec_pkg::word_t   pc,
    input  rv32_exec_pkg::word_t   rs1_d,
    input  rv32_exec_pkg::word_t   imm,
    output rv32_exec_pkg::word_t   dnpc
);
    rv32_exec_pkg::pc_sel_t src;
    rv32_exec_pkg::word_t   base;
    rv32_exec_pkg::word_t   offs;

    // branch outcome picks rel or seq unless the word names a source
    assign src = (pc_ctl != `PC_BRANCH) ? pc_ctl : (taken ? `PC_REL : `PC_SEQ);

    always_comb begin
        case (src)
            `PC_SEQ: begin
                base = pc;
                offs = 32'd4;
            end
            `PC_REL: begin
                base = pc;
                offs = imm;
            end
            // jalr base from rs1
            default: begin
                base = rs1_d;
                offs = imm;
            end
        endcase
    end

    // one adder for every source
    assign dnpc = base + offs;

    // retired ops always land on a word boundary
    a_dnpc_aligned: assert property (@(posedge clk) valid |-> (dnpc[1:0] == 2'b00));

endmodule

// File: rtl/rv32_exec_consts.svh
`ifndef RV32_EXEC_CONSTS_SVH
`define RV32_EXEC_CONSTS_SVH

// ----------------------------------------------------------------------
// control word field positions
// ----------------------------------------------------------------------
// operand select, 0 imm/0, 1 pc/imm, 2 rs1/rs2, 3 rs1/imm
`define OPT_SRC_LO 3
`define OPT_SRC_HI 4
`define OPT_ALU_LO 5
`define OPT_ALU_HI 7
`define OPT_PC_LO 8
`define OPT_PC_HI 9
`define OPT_MEM_LO 10
`define OPT_MEM_HI 11
// load when set, store when clear with a nonzero size
`define OPT_LOAD 12
`define OPT_EXT 13
`define OPT_SIGN 14
`define OPT_NEG 15

// ----------------------------------------------------------------------
// next pc sources
// ----------------------------------------------------------------------
`define PC_BRANCH 2'd0
`define PC_SEQ 2'd1
`define PC_REL 2'd2
`define PC_REG 2'd3

// core constants
`define RESET_PC 32'h8000_0000
`define DMEM_WORDS 256
`define DEFAULT_EXIT 32'd9

`endif

// File: rtl/rv32_exec_pkg.sv
package rv32_exec_pkg;

    // ------------------------------------------------------------------
    // datapath widths
    // ------------------------------------------------------------------
    // data and address word
    typedef logic [31:0] word_t;

    // decoded control word from the decoder
    typedef logic [15:0] opt_t;

    // alu operation code
    typedef logic [2:0] alu_op_t;

    // access size, 0 none, 1 byte, 2 half, 3 word
    typedef logic [1:0] mem_size_t;

    // next pc source code
    typedef logic [1:0] pc_sel_t;

    // ------------------------------------------------------------------
    // run control
    // ------------------------------------------------------------------
    // core keeps running until an ebreak-class word arrives
    typedef enum logic {
        RUNNING,
        HALTED
    } run_state_t;

endpackage

// File: rv32_exec.f
+incdir+rtl
rtl/rv32_exec_pkg.sv
rtl/exec_alu.sv
rtl/next_pc_unit.sv
rtl/data_mem.sv
rtl/exu.sv
rtl/core_state_regs.sv
rtl/exec_top.sv
bench/exec_tb.sv
